//--- design/stepper_pkg.sv
package stepper_pkg;

	// axis and accumulator geometry
	localparam int num_axes = 4;
	localparam int vel_w    = 12;
	localparam int frac_w   = 11;
	localparam int int_w    = 10;
	localparam int pos_w    = int_w + frac_w;   // 21
	localparam int time_w   = 4;

	// spi frame fields
	localparam int byte_w = 8;
	localparam int idx_w  = 5;
	localparam int dout_w = 14;
	localparam int din_w  = 16;

	// tick and watchdog timing
	localparam int tick_div      = 64;                 // clocks per tick
	localparam int tick_bits     = $clog2(tick_div);
	localparam int wdt_div_ticks = 32;                 // ticks per watchdog count
	localparam int presc_w       = tick_bits + $clog2(wdt_div_ticks);   // 2048 clocks
	localparam int wdt_w         = 8;
	localparam int wdt_limit     = 255;

	typedef logic signed [vel_w-1:0] vel_t;
	typedef logic [pos_w-1:0]        pos_t;
	typedef logic [time_w-1:0]       time_t;
	typedef logic [byte_w-1:0]       byte_t;
	typedef logic [idx_w-1:0]        byte_idx_t;
	typedef logic [dout_w-1:0]       dout_t;
	typedef logic [din_w-1:0]        din_t;

	// shared by all four axes
	typedef struct packed {
		time_t dirtime;    // ticks dir is held before a step
		time_t steptime;   // pulse width is steptime+1 ticks
		logic  polarity;   // inverts the step pins
	} step_timing_t;

endpackage

//--- design/spi_slave.sv
module spi_slave
	import stepper_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      sck,
	input  logic      ssel_n,
	input  logic      mosi,
	input  byte_t     tx_byte,
	output logic      miso,
	output byte_t     rx_byte,
	output logic      rx_valid,
	output byte_idx_t byte_idx
);

	logic [2:0] sck_r;    // two sync stages plus one for edge detect
	logic [2:0] sel_r;
	logic [1:0] mosi_r;
	logic [2:0] bit_cnt;
	byte_t      sh_in;
	byte_t      sh_out;
	logic       sck_rise;
	logic       sck_fall;
	logic       sel_active;
	logic       sel_start;

	always_ff @(posedge clk) begin
		if (rst) begin
			sck_r <= '0;
			sel_r <= '1;   // select idles inactive
		end else begin
			sck_r <= {sck_r[1:0], sck};
			sel_r <= {sel_r[1:0], ssel_n};
		end
	end

	// mosi lines up with sck_r[1]
	always_ff @(posedge clk) mosi_r <= {mosi_r[0], mosi};

	assign sck_rise   = (sck_r[2:1] == 2'b01);
	assign sck_fall   = (sck_r[2:1] == 2'b10);
	assign sel_active = ~sel_r[1];
	assign sel_start  = (sel_r[2:1] == 2'b10);   // falling select starts a frame

	always_ff @(posedge clk) begin
		if (rst) begin
			bit_cnt  <= '0;
			byte_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= sel_active && sck_rise && (bit_cnt == 3'd7);
			if (sel_start) begin
				bit_cnt  <= '0;
				byte_idx <= '0;
			end else if (sel_active) begin
				if (sck_rise)
					bit_cnt <= bit_cnt + 3'd1;
				else if (sck_fall && bit_cnt == '0)
					byte_idx <= byte_idx + 1'b1;   // first fall after a full byte
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sel_active && sck_rise) begin
			sh_in <= {sh_in[byte_w-2:0], mosi_r[1]};
			if (bit_cnt == '0)
				sh_out <= tx_byte;   // readback for this byte
		end else if (sel_active && sck_fall) begin
			sh_out <= {sh_out[byte_w-2:0], 1'b0};
		end
	end

	assign rx_byte = sh_in;
	assign miso    = sh_out[byte_w-1];   // msb first

	// a byte strobe only comes out of a live frame
	a_rx_in_frame: assert property (@(posedge clk) disable iff (rst)
		rx_valid |-> sel_active);

endmodule

//--- design/spi_regmap.sv
module spi_regmap
	import stepper_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  byte_t        rx_byte,
	input  logic         rx_valid,
	input  byte_idx_t    byte_idx,
	input  pos_t         pos [num_axes],
	input  din_t         din,
	output byte_t        tx_byte,
	output vel_t         vel [num_axes],
	output dout_t        dout,
	output step_timing_t timing,
	output logic         kick
);

	byte_t hold;      // low byte of the field in progress
	pos_t  rd_pos;

	// even bytes are the low halves
	always_ff @(posedge clk) begin
		if (rx_valid && !byte_idx[0])
			hold <= rx_byte;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < num_axes; i++) begin
				vel[i] <= '0;
			end
			dout   <= '0;
			timing <= '0;
			kick   <= 1'b0;
		end else begin
			kick <= 1'b0;
			if (rx_valid && byte_idx[0]) begin
				if (byte_idx < idx_w'(8)) begin
					// bytes 1,3,5,7 commit velocities 0..3
					vel[byte_idx[2:1]] <= {rx_byte[vel_w-byte_w-1:0], hold};
				end else if (byte_idx == idx_w'(9)) begin
					dout <= {rx_byte[dout_w-byte_w-1:0], hold};
					kick <= rx_byte[6];
				end else if (byte_idx == idx_w'(11)) begin
					// byte 11 bits 7:6 are the unused tap select
					timing.dirtime  <= hold[time_w-1:0];
					timing.polarity <= hold[7];
					timing.steptime <= rx_byte[time_w-1:0];
				end
			end
		end
	end

	assign rd_pos = pos[byte_idx[3:2]];   // four bytes per axis

	always_ff @(posedge clk) begin
		if (byte_idx < idx_w'(16)) begin
			case (byte_idx[1:0])
				2'd0:    tx_byte <= rd_pos[7:0];
				2'd1:    tx_byte <= rd_pos[15:8];
				2'd2:    tx_byte <= byte_t'(rd_pos[pos_w-1:16]);
				default: tx_byte <= '0;
			endcase
		end else begin
			case (byte_idx)
				idx_w'(16): tx_byte <= din[7:0];
				idx_w'(17): tx_byte <= din[15:8];
				idx_w'(18),
				idx_w'(19): tx_byte <= '0;
				default:    tx_byte <= byte_t'(byte_idx);   // past the map, echo index
			endcase
		end
	end

endmodule

//--- design/step_gen.sv
module step_gen
	import stepper_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         tick,
	input  vel_t         vel,
	input  step_timing_t timing,
	output pos_t         pos,
	output logic         step,
	output logic         dir
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_HOLD,    // dir just changed, waiting out dirtime
		ST_PULSE
	} state_t;

	state_t state;
	pos_t   pos_next;
	time_t  hold_cnt;
	time_t  pulse_cnt;
	logic   req;
	logic   pending;

	assign pos_next = pos + pos_t'(vel);   // sign extended, wraps at pos_w
	// |vel| < 2**frac_w so at most one toggle per tick
	assign req = tick && (pos_next[frac_w] != pos[frac_w]);

	always_ff @(posedge clk) begin
		if (rst) begin
			pos       <= '0;
			state     <= ST_IDLE;
			step      <= 1'b0;
			dir       <= 1'b0;
			hold_cnt  <= '0;
			pulse_cnt <= '0;
			pending   <= 1'b0;
		end else begin
			if (tick)
				pos <= pos_next;
			if (req)
				pending <= 1'b1;   // kept until idle
			if (tick) begin
				case (state)
					ST_IDLE: begin
						if (dir != vel[vel_w-1]) begin
							dir      <= vel[vel_w-1];
							hold_cnt <= timing.dirtime;
							state    <= ST_HOLD;
						end else if (pending || req) begin
							step      <= 1'b1;
							pulse_cnt <= timing.steptime;
							pending   <= 1'b0;
							state     <= ST_PULSE;
						end
					end
					ST_HOLD: begin
						if (hold_cnt == '0)
							state <= ST_IDLE;
						else
							hold_cnt <= hold_cnt - 1'b1;
					end
					ST_PULSE: begin
						if (pulse_cnt == '0) begin
							step  <= 1'b0;
							state <= ST_IDLE;
						end else begin
							pulse_cnt <= pulse_cnt - 1'b1;
						end
					end
					default: state <= ST_IDLE;
				endcase
			end
		end
	end

	// direction setup is never cut short by a new pulse
	a_dir_setup: assert property (@(posedge clk) disable iff (rst)
		$rose(step) |-> $past(hold_cnt) == '0 && $past(dir) == dir);

endmodule

//--- design/step_watchdog.sv
module step_watchdog
	import stepper_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic kick,
	input  logic wdt_tick,
	output logic drive_en
);

	logic [wdt_w-1:0] cnt;

	always_ff @(posedge clk) begin
		if (rst)
			cnt <= '0;   // outputs start disabled
		else if (kick)
			cnt <= wdt_w'(wdt_limit);
		else if (wdt_tick && cnt != '0)
			cnt <= cnt - 1'b1;
	end

	assign drive_en = (cnt != '0);

endmodule

//--- design/output_stage.sv
module output_stage
	import stepper_pkg::*;
(
	input  logic                clk,
	input  logic                rst,
	input  logic [num_axes-1:0] step_raw,
	input  logic [num_axes-1:0] dir_raw,
	input  logic                polarity,
	input  dout_t               dout_in,
	input  logic                drive_en_in,
	output logic [num_axes-1:0] step,
	output logic [num_axes-1:0] dir,
	output dout_t               dout,
	output logic                drive_en,
	output logic                led
);

	always_ff @(posedge clk) begin
		if (rst) begin
			step     <= '0;
			dir      <= '0;
			dout     <= '0;
			drive_en <= 1'b0;
			led      <= 1'b0;
		end else begin
			step     <= step_raw ^ {num_axes{polarity}};
			dir      <= dir_raw;
			dout     <= dout_in;
			drive_en <= drive_en_in;
			led      <= drive_en_in & (step_raw[0] ^ dir_raw[0]);   // axis 0 activity
		end
	end

	a_led_off: assert property (@(posedge clk) disable iff (rst) !drive_en |-> !led);

endmodule

//--- design/stepper_top.sv
module stepper_top
	import stepper_pkg::*;
(
	input  logic                clk,
	input  logic                rst,
	input  logic                sck,
	input  logic                ssel_n,
	input  logic                mosi,
	input  din_t                din,
	output logic                miso,
	output logic [num_axes-1:0] step,
	output logic [num_axes-1:0] dir,
	output dout_t               dout,
	output logic                drive_en,
	output logic                led
);

	logic [presc_w-1:0]  presc;
	logic                tick;
	logic                wdt_tick;
	byte_t               rx_byte;
	byte_t               tx_byte;
	logic                rx_valid;
	byte_idx_t           byte_idx;
	vel_t                vel [num_axes];
	pos_t                pos [num_axes];
	dout_t               dout_reg;
	step_timing_t        timing;
	logic                kick;
	logic [num_axes-1:0] step_raw;
	logic [num_axes-1:0] dir_raw;
	logic                drive_en_raw;

	always_ff @(posedge clk) begin
		if (rst)
			presc <= '0;
		else
			presc <= presc + 1'b1;
	end

	assign tick     = (presc[tick_bits-1:0] == '1);   // once per tick_div clocks
	assign wdt_tick = (presc == '1);                   // every 32nd tick

	spi_slave i_spi_slave (
		.clk, .rst, .sck, .ssel_n, .mosi,
		.tx_byte, .miso, .rx_byte, .rx_valid, .byte_idx
	);

	spi_regmap i_spi_regmap (
		.clk, .rst, .rx_byte, .rx_valid, .byte_idx, .pos, .din,
		.tx_byte, .vel, .dout(dout_reg), .timing, .kick
	);

	for (genvar i = 0; i < num_axes; i++) begin : g_axis
		step_gen i_step_gen (
			.clk, .rst, .tick,
			.vel(vel[i]), .timing, .pos(pos[i]),
			.step(step_raw[i]), .dir(dir_raw[i])
		);
	end

	step_watchdog i_step_watchdog (.clk, .rst, .kick, .wdt_tick, .drive_en(drive_en_raw));

	output_stage i_output_stage (
		.clk, .rst, .step_raw, .dir_raw, .polarity(timing.polarity),
		.dout_in(dout_reg), .drive_en_in(drive_en_raw),
		.step, .dir, .dout, .drive_en, .led
	);

endmodule

//--- tb/stepper_tb.sv
module stepper_tb
	import stepper_pkg::*;
();

	localparam int half_sck    = 10;   // clocks per sck half period
	localparam int frame_len   = 22;
	localparam int run_ticks   = 400;
	localparam int drain_ticks = 40;
	localparam int frame_cyc   = (frame_len * 16 + 4) * half_sck;
	localparam int test_cyc    = 10 * frame_cyc + (2 * run_ticks + 2 * drain_ticks + 20) * tick_div
		+ wdt_limit * 2048 + 2000;
	localparam int max_cycles  = 20 * test_cyc;

	logic                clk = 1'b0;
	logic                rst;
	logic                sck;
	logic                ssel_n;
	logic                mosi;
	din_t                din;
	logic                miso;
	logic [num_axes-1:0] step;
	logic [num_axes-1:0] dir;
	dout_t               dout;
	logic                drive_en;
	logic                led;

	logic [31:0]         lfsr_state = 32'h0e89dff3;
	byte_t               tx [24];
	byte_t               rx [24];
	vel_t                mvel [num_axes];     // model velocity, switched on the exact commit cycle
	vel_t                run_vel [num_axes];
	pos_t                mpos [num_axes];
	int                  exp_steps [num_axes];
	int                  pulses [num_axes];
	int                  base_exp [num_axes];
	int                  base_pulses [num_axes];
	logic                mpol;
	logic [num_axes-1:0] act;
	logic [num_axes-1:0] act_prev;
	int                  mc;
	int                  kick_cyc = 0;
	int                  cyc = 0;
	int                  checks = 0;
	int                  errors = 0;

	stepper_top i_stepper_top (
		.clk, .rst, .sck, .ssel_n, .mosi, .din,
		.miso, .step, .dir, .dout, .drive_en, .led
	);

	always #50 clk = ~clk;

	// reference integrator, one tick every tick_div clocks after reset
	always @(posedge clk) begin
		pos_t npos;
		if (rst) begin
			mc <= 0;
			for (int k = 0; k < num_axes; k++) begin
				mpos[k]      <= '0;
				exp_steps[k] <= 0;
			end
		end else begin
			mc <= mc + 1;
			if (mc % tick_div == tick_div - 1) begin
				for (int k = 0; k < num_axes; k++) begin
					npos = mpos[k] + pos_t'(mvel[k]);
					if (npos[pos_w-1:frac_w] != mpos[k][pos_w-1:frac_w])
						exp_steps[k] <= exp_steps[k] + 1;   // integer part moved
					mpos[k] <= npos;
				end
			end
		end
	end

	assign act = step ^ {num_axes{mpol}};   // active step level

	always @(posedge clk) begin
		if (rst) begin
			act_prev <= '0;
			for (int k = 0; k < num_axes; k++)
				pulses[k] <= 0;
		end else begin
			act_prev <= act;
			for (int k = 0; k < num_axes; k++)
				if (act[k] && !act_prev[k])
					pulses[k] <= pulses[k] + 1;
		end
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= max_cycles) begin
			$display("timeout: run did not finish within %0d cycles", max_cycles);
			$display("checks %0d, errors %0d", checks, errors);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
	endtask

	task automatic wait_clocks(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error: %s got %h exp %h", name, got, exp);
		end
	endtask

	// mode 0 master, msb first, miso sampled just before each falling sck
	task automatic spi_frame(input int n);
		byte_t sh;
		ssel_n = 1'b0;
		wait_clocks(half_sck);
		for (int b = 0; b < n; b++) begin
			sh = tx[b];
			for (int i = 7; i >= 0; i--) begin
				mosi = sh[i];
				wait_clocks(half_sck);
				sck = 1'b1;
				if (b == 9 && i == 0 && tx[9][6])
					kick_cyc = cyc;   // kick lands a few clocks later
				if (i == 0 && b < 8 && b % 2 == 1) begin
					wait_clocks(4);   // sync, strobe and write take 4 clocks
					mvel[b / 2] = vel_t'({tx[b], tx[b-1]});
					wait_clocks(half_sck - 4);
				end else begin
					wait_clocks(half_sck);
				end
				rx[b][i] = miso;
				sck = 1'b0;
			end
		end
		wait_clocks(half_sck);
		ssel_n = 1'b1;
		wait_clocks(half_sck);
	endtask

	task automatic load_velocities(input logic random_vel);
		logic [31:0] r;
		vel_t        v;
		for (int k = 0; k < num_axes; k++) begin
			v = '0;
			if (random_vel) begin
				take_bits(8, r);
				v = vel_t'(r[6:0] | 7'd32);   // slow enough that requests never pile up
				if (r[7])
					v = -v;
				run_vel[k] = v;
			end
			tx[2*k]   = v[7:0];
			tx[2*k+1] = {{4{v[vel_w-1]}}, v[vel_w-1:8]};
		end
	endtask

	task automatic check_pulses();
		for (int k = 0; k < num_axes; k++)
			check_val($sformatf("pulses[%0d]", k), 32'(pulses[k] - base_pulses[k]),
				32'(exp_steps[k] - base_exp[k]));
	endtask

	initial begin
		logic [31:0]            r;
		logic [31:0]            dwr;
		logic signed [pos_w-1:0] diff;
		int                     tol;
		rst    = 1'b1;
		sck    = 1'b0;
		ssel_n = 1'b1;
		mosi   = 1'b0;
		din    = '0;
		mpol   = 1'b0;
		for (int k = 0; k < num_axes; k++) begin
			mvel[k]        = '0;
			run_vel[k]     = '0;
			base_exp[k]    = 0;
			base_pulses[k] = 0;
		end
		for (int b = 0; b < 24; b++)
			tx[b] = '0;
		wait_clocks(10);
		rst = 1'b0;
		wait_clocks(4);

		// reset state and readback map
		check_val("drive_en", 32'(drive_en), 32'h0);
		check_val("led", 32'(led), 32'h0);
		check_val("step", 32'(step), 32'h0);
		check_val("dout", 32'(dout), 32'h0);
		take_bits(16, r);
		din = r[15:0];
		spi_frame(frame_len);
		for (int b = 0; b < 16; b++)
			check_val($sformatf("rx[%0d]", b), 32'(rx[b]), 32'h0);
		check_val("rx[16]", 32'(rx[16]), 32'(din[7:0]));
		check_val("rx[17]", 32'(rx[17]), 32'(din[15:8]));
		check_val("rx[18]", 32'(rx[18]), 32'h0);
		check_val("rx[19]", 32'(rx[19]), 32'h0);
		check_val("rx[20]", 32'(rx[20]), 32'd20);
		check_val("rx[21]", 32'(rx[21]), 32'd21);

		// dout, kick, timing and a velocity run
		take_bits(14, dwr);
		tx[8]  = dwr[7:0];
		tx[9]  = {1'b0, 1'b1, dwr[13:8]};
		tx[10] = 8'h02;   // dirtime 2
		tx[11] = 8'h01;   // steptime 1
		load_velocities(1'b1);
		spi_frame(frame_len);
		tx[9][6] = 1'b0;
		wait_clocks(4);
		check_val("dout", 32'(dout), 32'(dwr[13:0]));
		check_val("drive_en", 32'(drive_en), 32'h1);
		wait_clocks(run_ticks * tick_div);
		for (int k = 0; k < num_axes; k++)
			check_val($sformatf("dir[%0d]", k), 32'(dir[k]), 32'(run_vel[k][vel_w-1]));
		load_velocities(1'b0);
		spi_frame(frame_len);
		wait_clocks(drain_ticks * tick_div);
		spi_frame(frame_len);   // positions stand still during this read
		for (int k = 0; k < num_axes; k++) begin
			diff = {rx[4*k+2][4:0], rx[4*k+1], rx[4*k]} - mpos[k];
			tol  = (run_vel[k] < 0) ? -int'(run_vel[k]) : int'(run_vel[k]);
			checks++;
			if (int'(diff) < -tol || int'(diff) > tol) begin
				errors++;
				$display("error: pos[%0d] got %h exp %h", k,
					{rx[4*k+2][4:0], rx[4*k+1], rx[4*k]}, mpos[k]);
			end
			check_val($sformatf("rx[%0d][7:5]", 4*k+2), 32'(rx[4*k+2][7:5]), 32'h0);
			check_val($sformatf("rx[%0d]", 4*k+3), 32'(rx[4*k+3]), 32'h0);
		end
		check_pulses();

		// inverted step polarity
		tx[10][7] = 1'b1;
		spi_frame(frame_len);
		wait_clocks(4);
		mpol = 1'b1;
		check_val("step", 32'(step), 32'hf);
		for (int k = 0; k < num_axes; k++) begin
			base_exp[k]    = exp_steps[k];
			base_pulses[k] = pulses[k];
		end
		load_velocities(1'b1);
		spi_frame(frame_len);
		wait_clocks(run_ticks * tick_div);
		load_velocities(1'b0);
		spi_frame(frame_len);
		wait_clocks(drain_ticks * tick_div);
		check_pulses();
		check_val("step", 32'(step), 32'hf);

		// axis 0 reverses, led follows dir while the step waits out dirtime
		tx[10][7] = 1'b0;
		spi_frame(frame_len);
		tx[0] = 8'hff;
		tx[1] = 8'hff;
		spi_frame(2);
		wait_clocks(tick_div);
		check_val("dir[0]", 32'(dir[0]), 32'h1);
		check_val("led", 32'(led), 32'h1);

		// no kick since the dout frame, so the watchdog runs out
		while (drive_en && cyc - kick_cyc <= wdt_limit * 2048 + tick_div)
			wait_clocks(1);
		checks++;
		if (drive_en) begin
			errors++;
			$display("drive_en still high after the watchdog period ran out");
		end else if (cyc - kick_cyc < (wdt_limit - 1) * 2048) begin
			errors++;
			$display("drive_en fell after %0d cycles, before the watchdog period was over",
				cyc - kick_cyc);
		end
		wait_clocks(2);
		check_val("led", 32'(led), 32'h0);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- list.f
design/stepper_pkg.sv
design/spi_slave.sv
design/spi_regmap.sv
design/step_gen.sv
design/step_watchdog.sv
design/output_stage.sv
design/stepper_top.sv
tb/stepper_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= stepper_tb
FILELIST  ?= list.f
OBJDIR    ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "TEST OK"

clean:
	rm -rf $(OBJDIR)
